// ==== src.f ====
verilog/axi_mem_pkg.sv
verilog/sram_core.sv
verilog/axi_sram_slave.sv
verilog/axi_read_arbiter.sv
verilog/axi_mem_top.sv
verification/tb_axi_mem_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_axi_mem_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TB PASSED

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_axi_mem_top.sv ====
// testbench for the two-master memory subsystem with random traffic checked against a word model
`default_nettype none

module tb_axi_mem_top
	import axi_mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS       = 256;
	localparam int POOL_SIZE       = 32;	// words written before any read
	localparam int NUM_TX          = 400;
	localparam int WATCHDOG_CYCLES = 16 + (POOL_SIZE + NUM_TX) * 40;

	logic clk;
	logic rstn;

	// read ports indexed by master with 0 for ifetch and 1 for lsu
	axi_ar_t    ar [2];
	logic [1:0] ar_valid;
	logic [1:0] ar_ready;
	axi_r_t     r [2];
	logic [1:0] r_valid;
	logic [1:0] r_ready;

	// lsu write channels
	axi_aw_t aw;
	logic    aw_valid;
	logic    aw_ready;
	axi_w_t  w;
	logic    w_valid;
	logic    w_ready;
	axi_b_t  b;
	logic    b_valid;
	logic    b_ready;

	logic [31:0] model_mem [int unsigned];	// expected contents by word index
	int unsigned pool [$];	// word indices with known contents
	bit          last_grant;	// read master granted most recently

	axi_mem_top #(
		.MEM_WORDS (MEM_WORDS)
	) axi_mem_top_inst (
		.clk_i         (clk),
		.rstn_i        (rstn),
		.m0_ar_i       (ar[0]),
		.m0_ar_valid_i (ar_valid[0]),
		.m0_ar_ready_o (ar_ready[0]),
		.m0_r_o        (r[0]),
		.m0_r_valid_o  (r_valid[0]),
		.m0_r_ready_i  (r_ready[0]),
		.m1_ar_i       (ar[1]),
		.m1_ar_valid_i (ar_valid[1]),
		.m1_ar_ready_o (ar_ready[1]),
		.m1_r_o        (r[1]),
		.m1_r_valid_o  (r_valid[1]),
		.m1_r_ready_i  (r_ready[1]),
		.aw_i          (aw),
		.aw_valid_i    (aw_valid),
		.aw_ready_o    (aw_ready),
		.w_i           (w),
		.w_valid_i     (w_valid),
		.w_ready_o     (w_ready),
		.b_o           (b),
		.b_valid_o     (b_valid),
		.b_ready_i     (b_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, a handshake never completed",
			WATCHDOG_CYCLES);
		abort_run();
	end

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	// next drive point just after the rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = data[8*i +: 8];
			end
		end
		return res;
	endfunction

	function automatic logic [31:0] pick_addr();
		return pool[$urandom_range(0, pool.size() - 1)] << 2;
	endfunction

	// just past the last word or anywhere higher up
	function automatic logic [31:0] far_addr();
		logic [31:0] addr;
		addr = $urandom_range(0, 1) ? MEM_WORDS * 4 + 4 * $urandom_range(0, 15)
			: ($urandom() | MEM_WORDS * 4);
		addr[1:0] = 2'b00;
		return addr;
	endfunction

	task automatic check_idle();
		check_value("m0_r_valid", r_valid[0], 1'b0);
		check_value("m1_r_valid", r_valid[1], 1'b0);
		check_value("b_valid", b_valid, 1'b0);
	endtask

	// one read on a master port with random valid and ready delays
	task automatic read_word(input bit port, input logic [31:0] addr, input int lead,
			output axi_r_t got);
		int hold;
		repeat (lead) step();
		ar[port].addr  = addr;
		ar_valid[port] = 1'b1;
		@(negedge clk);
		while (!ar_ready[port]) begin
			@(negedge clk);
		end
		check_value($sformatf("m%0d_r_valid", port), r_valid[port], 1'b0);
		step();	// ar handshake edge
		last_grant     = port;
		ar_valid[port] = 1'b0;
		hold = $urandom_range(0, 3);
		for (int c = 0; c <= hold; c++) begin
			r_ready[port] = (c == hold);
			@(negedge clk);
			check_value($sformatf("m%0d_r_valid", port), r_valid[port], 1'b1);
			check_value("m0_ar_ready", ar_ready[0], 1'b0);	// locked until the r handshake
			check_value("m1_ar_ready", ar_ready[1], 1'b0);
			if (c == 0) begin
				got = r[port];	// first cycle of rvalid
			end
			check_value($sformatf("m%0d_r", port), r[port], got);
			step();
		end
		r_ready[port] = 1'b0;
	endtask

	task automatic check_read(input bit port, input logic [31:0] addr, input axi_r_t got);
		logic [31:0] exp_data;
		logic [1:0]  exp_resp;
		exp_data = '0;	// zero data on slverr
		exp_resp = RESP_SLVERR;
		if (addr < MEM_WORDS * 4) begin
			exp_data = model_mem[addr >> 2];
			exp_resp = RESP_OKAY;
		end
		check_value($sformatf("m%0d_r.resp", port), got.resp, exp_resp);
		check_value($sformatf("m%0d_r.data", port), got.data, exp_data);
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int hold;
		repeat ($urandom_range(0, 2)) step();
		aw.addr  = addr;
		w.data   = data;
		w.strb   = strb;
		aw_valid = 1'b1;
		w_valid  = 1'b1;
		@(negedge clk);
		while (!(aw_ready && w_ready)) begin
			@(negedge clk);
		end
		check_value("b_valid", b_valid, 1'b0);
		step();	// aw and w handshake edge
		aw_valid = 1'b0;
		w_valid  = 1'b0;
		hold = $urandom_range(0, 3);
		for (int c = 0; c <= hold; c++) begin
			b_ready = (c == hold);
			@(negedge clk);
			check_value("b_valid", b_valid, 1'b1);
			check_value("aw_ready", aw_ready, 1'b0);	// nothing new while b is pending
			check_value("w_ready", w_ready, 1'b0);
			if (c == 0) begin
				resp = b.resp;
			end
			check_value("b.resp", b.resp, resp);
			step();
		end
		b_ready = 1'b0;
	endtask

	task automatic write_and_check(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		logic [1:0]  resp;
		logic [31:0] old;
		write_word(addr, data, strb, resp);
		if (addr < MEM_WORDS * 4) begin
			check_value("b.resp", resp, RESP_OKAY);
			old = model_mem.exists(addr >> 2) ? model_mem[addr >> 2] : 'x;
			model_mem[addr >> 2] = merge_bytes(old, data, strb);
		end else begin
			check_value("b.resp", resp, RESP_SLVERR);	// memory left as it was
		end
	endtask

	// both masters request in the same cycle
	task automatic dual_read();
		logic [31:0] addr0;
		logic [31:0] addr1;
		axi_r_t      got0;
		axi_r_t      got1;
		bit          winner;
		addr0  = pick_addr();
		addr1  = pick_addr();
		winner = !last_grant;	// tie goes to the master not granted last
		fork
			read_word(1'b0, addr0, 0, got0);
			read_word(1'b1, addr1, 0, got1);
			begin
				@(negedge clk);
				check_value($sformatf("m%0d_ar_ready", winner), ar_ready[winner], 1'b1);
				check_value($sformatf("m%0d_ar_ready", !winner), ar_ready[!winner], 1'b0);
			end
		join
		check_read(1'b0, addr0, got0);
		check_read(1'b1, addr1, got1);
	endtask

	initial begin
		logic [31:0] addr;
		axi_r_t      got;
		int unsigned kind;
		int unsigned idx;
		bit          port;
		ar[0]      = '0;
		ar[1]      = '0;
		ar_valid   = '0;
		r_ready    = '0;
		aw         = '0;
		aw_valid   = 1'b0;
		w          = '0;
		w_valid    = 1'b0;
		b_ready    = 1'b0;
		rstn       = 1'b1;
		last_grant = 1'b0;	// ifetch counts as granted last
		void'($urandom(32'ha6b7));
		repeat (16) begin
			step();
			check_idle();
		end
		rstn = 1'b0;
		@(negedge clk);
		check_idle();
		step();
		// full-word writes give every pool location a known value
		while (pool.size() < POOL_SIZE) begin
			idx = $urandom_range(0, MEM_WORDS - 1);
			if (!model_mem.exists(idx)) begin
				pool.push_back(idx);
				write_and_check(idx << 2, $urandom(), 4'hf);
			end
		end
		for (int n = 0; n < NUM_TX; n++) begin
			kind = $urandom_range(0, 9);
			if (kind < 3) begin
				write_and_check(pick_addr(), $urandom(), 4'($urandom_range(0, 15)));
			end else if (kind == 3) begin
				write_and_check(far_addr(), $urandom(), 4'($urandom_range(0, 15)));
			end else if (kind < 9) begin
				addr = (kind == 8) ? far_addr() : pick_addr();
				port = (kind == 8) ? 1'($urandom_range(0, 1)) : (kind >= 6);
				read_word(port, addr, $urandom_range(0, 2), got);
				check_read(port, addr, got);
			end else begin
				dual_read();
			end
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/axi_mem_top.sv ====
// memory subsystem top joining the read arbiter, axi-lite slave and sram for two masters
`default_nettype none

module axi_mem_top
	import axi_mem_pkg::*;
#(
	parameter int MEM_WORDS = MEM_WORDS_DEF
) (
	input  wire logic    clk_i,
	input  wire logic    rstn_i,	// sync, active high

	// ifetch read port
	input  wire axi_ar_t m0_ar_i,
	input  wire logic    m0_ar_valid_i,
	output logic         m0_ar_ready_o,
	output axi_r_t       m0_r_o,
	output logic         m0_r_valid_o,
	input  wire logic    m0_r_ready_i,

	// lsu read port
	input  wire axi_ar_t m1_ar_i,
	input  wire logic    m1_ar_valid_i,
	output logic         m1_ar_ready_o,
	output axi_r_t       m1_r_o,
	output logic         m1_r_valid_o,
	input  wire logic    m1_r_ready_i,

	// lsu write channels
	input  wire axi_aw_t aw_i,
	input  wire logic    aw_valid_i,
	output logic         aw_ready_o,
	input  wire axi_w_t  w_i,
	input  wire logic    w_valid_i,
	output logic         w_ready_o,
	output axi_b_t       b_o,
	output logic         b_valid_o,
	input  wire logic    b_ready_i
);

	localparam int IDX_W = $clog2(MEM_WORDS);

	// shared read channel
	axi_ar_t s_ar;
	logic    s_ar_valid;
	logic    s_ar_ready;
	axi_r_t  s_r;
	logic    s_r_valid;
	logic    s_r_ready;

	// sram port
	logic              mem_en;
	logic              mem_we;
	logic [STRB_W-1:0] mem_be;
	logic [IDX_W-1:0]  mem_index;
	logic [DATA_W-1:0] mem_wdata;
	logic [DATA_W-1:0] mem_rdata;

	axi_read_arbiter arbiter_inst (
		.clk_i         (clk_i),
		.rstn_i        (rstn_i),
		.m0_ar_i       (m0_ar_i),
		.m0_ar_valid_i (m0_ar_valid_i),
		.m0_ar_ready_o (m0_ar_ready_o),
		.m0_r_o        (m0_r_o),
		.m0_r_valid_o  (m0_r_valid_o),
		.m0_r_ready_i  (m0_r_ready_i),
		.m1_ar_i       (m1_ar_i),
		.m1_ar_valid_i (m1_ar_valid_i),
		.m1_ar_ready_o (m1_ar_ready_o),
		.m1_r_o        (m1_r_o),
		.m1_r_valid_o  (m1_r_valid_o),
		.m1_r_ready_i  (m1_r_ready_i),
		.s_ar_o        (s_ar),
		.s_ar_valid_o  (s_ar_valid),
		.s_ar_ready_i  (s_ar_ready),
		.s_r_i         (s_r),
		.s_r_valid_i   (s_r_valid),
		.s_r_ready_o   (s_r_ready)
	);

	axi_sram_slave #(
		.MEM_WORDS (MEM_WORDS)
	) slave_inst (
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.ar_i        (s_ar),
		.ar_valid_i  (s_ar_valid),
		.ar_ready_o  (s_ar_ready),
		.r_o         (s_r),
		.r_valid_o   (s_r_valid),
		.r_ready_i   (s_r_ready),
		.aw_i        (aw_i),
		.aw_valid_i  (aw_valid_i),
		.aw_ready_o  (aw_ready_o),
		.w_i         (w_i),
		.w_valid_i   (w_valid_i),
		.w_ready_o   (w_ready_o),
		.b_o         (b_o),
		.b_valid_o   (b_valid_o),
		.b_ready_i   (b_ready_i),
		.mem_en_o    (mem_en),
		.mem_we_o    (mem_we),
		.mem_be_o    (mem_be),
		.mem_index_o (mem_index),
		.mem_wdata_o (mem_wdata),
		.mem_rdata_i (mem_rdata)
	);

	sram_core #(
		.MEM_WORDS (MEM_WORDS)
	) sram_inst (
		.clk_i   (clk_i),
		.rstn_i  (rstn_i),
		.en_i    (mem_en),
		.we_i    (mem_we),
		.be_i    (mem_be),
		.index_i (mem_index),
		.wdata_i (mem_wdata),
		.rdata_o (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== verilog/axi_read_arbiter.sv ====
// round-robin arbiter locking one of two read masters onto the shared read channel
`default_nettype none

module axi_read_arbiter
	import axi_mem_pkg::*;
(
	input  wire logic    clk_i,
	input  wire logic    rstn_i,	// sync, active high

	// m0, instruction fetch
	input  wire axi_ar_t m0_ar_i,
	input  wire logic    m0_ar_valid_i,
	output logic         m0_ar_ready_o,
	output axi_r_t       m0_r_o,
	output logic         m0_r_valid_o,
	input  wire logic    m0_r_ready_i,

	// m1, load/store
	input  wire axi_ar_t m1_ar_i,
	input  wire logic    m1_ar_valid_i,
	output logic         m1_ar_ready_o,
	output axi_r_t       m1_r_o,
	output logic         m1_r_valid_o,
	input  wire logic    m1_r_ready_i,

	// shared slave side
	output axi_ar_t      s_ar_o,
	output logic         s_ar_valid_o,
	input  wire logic    s_ar_ready_i,
	input  wire axi_r_t  s_r_i,
	input  wire logic    s_r_valid_i,
	output logic         s_r_ready_o
);

	logic lock_q;
	logic grant_q;	// locked master, or the last one granted while unlocked
	logic pick;
	logic sel;

	// on a tie the master not granted last wins
	assign pick = m1_ar_valid_i && (!m0_ar_valid_i || !grant_q);
	assign sel  = lock_q ? grant_q : pick;

	assign s_ar_o       = sel ? m1_ar_i : m0_ar_i;
	assign s_ar_valid_o = !lock_q && (sel ? m1_ar_valid_i : m0_ar_valid_i);

	assign m0_ar_ready_o = !lock_q && !sel && s_ar_ready_i;
	assign m1_ar_ready_o = !lock_q && sel && s_ar_ready_i;

	// response goes back only to the lock holder
	assign m0_r_o       = s_r_i;
	assign m1_r_o       = s_r_i;
	assign m0_r_valid_o = lock_q && !grant_q && s_r_valid_i;
	assign m1_r_valid_o = lock_q && grant_q && s_r_valid_i;
	assign s_r_ready_o  = lock_q && (grant_q ? m1_r_ready_i : m0_r_ready_i);

	always_ff @(posedge clk_i) begin
		if (rstn_i) begin
			lock_q  <= 1'b0;
			grant_q <= 1'b0;	// ifetch counts as granted last
		end else if (!lock_q && s_ar_valid_o && s_ar_ready_i) begin
			lock_q  <= 1'b1;
			grant_q <= sel;
		end else if (lock_q && s_r_valid_i && s_r_ready_o) begin
			lock_q <= 1'b0;
		end
	end

	// granted master sees its data next cycle, the other is held off
	assert property (@(posedge clk_i) disable iff (rstn_i)
		(m0_ar_valid_i && m0_ar_ready_o) |=> (m0_r_valid_o && !m1_ar_ready_o));

	assert property (@(posedge clk_i) disable iff (rstn_i)
		(m1_ar_valid_i && m1_ar_ready_o) |=> (m1_r_valid_o && !m0_ar_ready_o));

endmodule

`default_nettype wire

// ==== verilog/axi_sram_slave.sv ====
// axi-lite slave controller that turns channel handshakes into sram accesses and responses
`default_nettype none

module axi_sram_slave
	import axi_mem_pkg::*;
#(
	parameter int MEM_WORDS = MEM_WORDS_DEF,
	localparam int IDX_W = $clog2(MEM_WORDS)
) (
	input  wire logic              clk_i,
	input  wire logic              rstn_i,	// sync, active high

	// read address
	input  wire axi_ar_t           ar_i,
	input  wire logic              ar_valid_i,
	output logic                   ar_ready_o,

	// read data
	output axi_r_t                 r_o,
	output logic                   r_valid_o,
	input  wire logic              r_ready_i,

	// write address
	input  wire axi_aw_t           aw_i,
	input  wire logic              aw_valid_i,
	output logic                   aw_ready_o,

	// write data
	input  wire axi_w_t            w_i,
	input  wire logic              w_valid_i,
	output logic                   w_ready_o,

	// write response
	output axi_b_t                 b_o,
	output logic                   b_valid_o,
	input  wire logic              b_ready_i,

	// sram side
	output logic                   mem_en_o,
	output logic                   mem_we_o,
	output logic      [STRB_W-1:0] mem_be_o,
	output logic      [IDX_W-1:0]  mem_index_o,
	output logic      [DATA_W-1:0] mem_wdata_o,
	input  wire logic [DATA_W-1:0] mem_rdata_i
);

	typedef enum logic [1:0] {
		IDLE,
		READ_RESP,
		WRITE_RESP
	} state_t;

	state_t     state_q;
	state_t     state_d;
	logic [1:0] resp_q;	// response of the transaction in flight

	logic idle;
	logic rd_acc;
	logic wr_acc;
	logic ar_in_range;
	logic aw_in_range;

	assign idle = (state_q == IDLE);

	assign ar_ready_o = idle;
	assign aw_ready_o = idle;
	assign w_ready_o  = idle;

	// read wins over a write arriving in the same cycle
	assign rd_acc = idle && ar_valid_i;
	assign wr_acc = idle && aw_valid_i && w_valid_i && !ar_valid_i;

	// nothing set above the word index and byte offset
	assign ar_in_range = ((ar_i.addr >> (IDX_W + 2)) == '0);
	assign aw_in_range = ((aw_i.addr >> (IDX_W + 2)) == '0);

	// sram access happens on the handshake edge
	assign mem_en_o    = (rd_acc && ar_in_range) || (wr_acc && aw_in_range);
	assign mem_we_o    = wr_acc;
	assign mem_be_o    = w_i.strb;
	assign mem_index_o = rd_acc ? ar_i.addr[IDX_W+1:2] : aw_i.addr[IDX_W+1:2];
	assign mem_wdata_o = w_i.data;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (rd_acc) begin
					state_d = READ_RESP;
				end else if (wr_acc) begin
					state_d = WRITE_RESP;
				end
			end
			READ_RESP: begin
				if (r_ready_i) begin
					state_d = IDLE;
				end
			end
			WRITE_RESP: begin
				if (b_ready_i) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rstn_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// range decoded once on acceptance
	always_ff @(posedge clk_i) begin
		if (rd_acc) begin
			resp_q <= ar_in_range ? RESP_OKAY : RESP_SLVERR;
		end else if (wr_acc) begin
			resp_q <= aw_in_range ? RESP_OKAY : RESP_SLVERR;
		end
	end

	assign r_valid_o = (state_q == READ_RESP);
	assign r_o.resp  = resp_q;
	assign r_o.data  = (resp_q == RESP_OKAY) ? mem_rdata_i : '0;	// zero on slverr

	assign b_valid_o = (state_q == WRITE_RESP);
	assign b_o.resp  = resp_q;

	// write response held until taken
	assert property (@(posedge clk_i) disable iff (rstn_i)
		(b_valid_o && !b_ready_i) |=> (b_valid_o && $stable(b_o)));

	// read response held steady under back-pressure
	assert property (@(posedge clk_i) disable iff (rstn_i)
		(r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_o)));

endmodule

`default_nettype wire

// ==== verilog/sram_core.sv ====
// single-port word sram with byte-masked write and registered read data
`default_nettype none

module sram_core
	import axi_mem_pkg::*;
#(
	parameter int MEM_WORDS = MEM_WORDS_DEF,
	localparam int IDX_W = $clog2(MEM_WORDS)
) (
	input  wire logic              clk_i,
	input  wire logic              rstn_i,	// sync, active high

	input  wire logic              en_i,
	input  wire logic              we_i,
	input  wire logic [STRB_W-1:0] be_i,
	input  wire logic [IDX_W-1:0]  index_i,
	input  wire logic [DATA_W-1:0] wdata_i,
	output logic      [DATA_W-1:0] rdata_o
);

	logic [DATA_W-1:0] mem_q [MEM_WORDS];

	// byte lanes written only where the mask is set
	always_ff @(posedge clk_i) begin
		if (en_i && we_i) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (be_i[b]) begin
					mem_q[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
		end
	end

	// read port, holds the last word until the next read
	always_ff @(posedge clk_i) begin
		if (rstn_i) begin
			rdata_o <= '0;
		end else if (en_i && !we_i) begin
			rdata_o <= mem_q[index_i];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/axi_mem_pkg.sv ====
// axi-lite memory subsystem package with channel payloads, response codes and default sizes
`default_nettype none

package axi_mem_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;	// fixed, strobe is 4 bits
	localparam int STRB_W = DATA_W / 8;

	localparam int MEM_WORDS_DEF = 256;	// depth in words, power of two

	// response codes on r and b
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// read address channel
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} axi_ar_t;

	// read data channel
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
	} axi_r_t;

	// write address channel
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} axi_aw_t;

	// write data channel, one strobe bit per byte
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} axi_w_t;

	// write response channel
	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

endpackage

`default_nettype wire
